/* all.f */
+incdir+include
hdl/fsync_pkg.sv
hdl/fsync_ingress.sv
hdl/fsync_node.sv
hdl/fsync_level.sv
hdl/fsync_tree.sv
sim/tb_fsync_tree.sv

/* hdl/fsync_ingress.sv */
// Ingress stage that registers CU requests and answers bad ones with an error

`timescale 1ns/1ps

`include "fsync_cfg.svh"

module fsync_ingress (
  input  logic                clk_i,
  input  logic                arst_n_i,

  input  fsync_pkg::cu_mask_t req_valid_i,
  input  fsync_pkg::lvl_t     req_lvl_i [`FSYNC_N_CU],
  input  fsync_pkg::id_t      req_id_i  [`FSYNC_N_CU],

  input  fsync_pkg::cu_mask_t wake_i,

  output fsync_pkg::cu_mask_t up_valid_o,
  output fsync_pkg::lvl_t     up_lvl_o [`FSYNC_N_CU],
  output fsync_pkg::id_t      up_id_o  [`FSYNC_N_CU],

  output fsync_pkg::cu_mask_t err_o
);

  import fsync_pkg::*;

  localparam lvl_t MAX_LVL = lvl_t'(`FSYNC_N_LEVELS);

  // CUs with a request in flight somewhere in the tree
  cu_mask_t waiting_q;

  cu_mask_t busy;
  cu_mask_t lvl_ok;
  cu_mask_t accept;
  cu_mask_t reject;

  // Level 0 is never a barrier, anything above the root is out of range
  always_comb begin
    for (int i = 0; i < `FSYNC_N_CU; i++) begin
      lvl_ok[i] = (req_lvl_i[i] != '0) && (req_lvl_i[i] <= MAX_LVL);
    end
  end

  // A wake in this cycle frees the CU for a new request
  assign busy   = waiting_q & ~wake_i;

  assign accept = req_valid_i & lvl_ok & ~busy;
  assign reject = req_valid_i & ~accept;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      waiting_q  <= '0;
      up_valid_o <= '0;
      err_o      <= '0;
    end else begin
      waiting_q  <= busy | accept;
      up_valid_o <= accept;
      err_o      <= reject;
    end
  end

  // Request fields follow the valid by one cycle like the flags
  always_ff @(posedge clk_i) begin
    up_lvl_o <= req_lvl_i;
    up_id_o  <= req_id_i;
  end

  // The tree only ever wakes CUs that are still waiting on it
  a_wake_waiting : assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    (wake_i & ~waiting_q) == '0
  ) else $error("Wake delivered to a CU with no request outstanding");

endmodule : fsync_ingress

/* hdl/fsync_level.sv */
// One tree level with its nodes and the registered up and down paths

`timescale 1ns/1ps

`include "fsync_cfg.svh"

module fsync_level #(
  parameter int unsigned LEVEL   = 1,
  parameter int unsigned N_NODES = 8
) (
  input  logic                 clk_i,
  input  logic                 arst_n_i,

  // Requests from the level below
  input  logic [2*N_NODES-1:0] up_valid_i,
  input  fsync_pkg::lvl_t      up_lvl_i [2*N_NODES],
  input  fsync_pkg::id_t       up_id_i  [2*N_NODES],

  // Requests toward the level above
  output logic [N_NODES-1:0]   up_valid_o,
  output fsync_pkg::lvl_t      up_lvl_o [N_NODES],
  output fsync_pkg::id_t       up_id_o  [N_NODES],

  // Wakes from the level above
  input  logic [N_NODES-1:0]   dn_wake_i,
  input  fsync_pkg::lvl_t      dn_lvl_i [N_NODES],
  input  fsync_pkg::id_t       dn_id_i  [N_NODES],

  // Wakes toward the level below
  output logic [2*N_NODES-1:0] dn_wake_o,
  output fsync_pkg::lvl_t      dn_lvl_o [2*N_NODES],
  output fsync_pkg::id_t       dn_id_o  [2*N_NODES]
);

  import fsync_pkg::*;

  function automatic int unsigned isqrt(input int unsigned val);
    int unsigned root;
    root = 0;
    for (int unsigned k = 1; k <= val; k++) begin
      if (k * k <= val) begin
        root = k;
      end
    end
    return root;
  endfunction

  // Even levels see a grid twice as tall as wide, so sqrt of the nodes gives its width
  localparam int unsigned COLS    = isqrt(N_NODES);
  localparam lvl_t        OWN_LVL = lvl_t'(LEVEL);

  logic [N_NODES-1:0]   par_valid;
  lvl_t                 par_lvl  [N_NODES];
  id_t                  par_id   [N_NODES];

  logic [N_NODES-1:0]   own_wake;
  lvl_t                 own_lvl  [N_NODES];
  id_t                  own_id   [N_NODES];

  logic [2*N_NODES-1:0] dn_wake_d;
  lvl_t                 dn_lvl_d [2*N_NODES];
  id_t                  dn_id_d  [2*N_NODES];

  for (genvar n = 0; n < N_NODES; n++) begin : gen_node
    // Odd levels pair row neighbours, even levels pair column neighbours
    localparam int unsigned CH0 = (LEVEL % 2 == 1) ? 2 * n :
                                  (n / COLS) * 2 * COLS + (n % COLS);
    localparam int unsigned CH1 = (LEVEL % 2 == 1) ? 2 * n + 1 : CH0 + COLS;

    logic [1:0] ch_valid;
    lvl_t       ch_lvl [2];
    id_t        ch_id  [2];
    logic       node_wake;

    assign ch_valid  = {up_valid_i[CH1], up_valid_i[CH0]};
    assign ch_lvl[0] = up_lvl_i[CH0];
    assign ch_lvl[1] = up_lvl_i[CH1];
    assign ch_id[0]  = up_id_i[CH0];
    assign ch_id[1]  = up_id_i[CH1];

    fsync_node #(
      .LEVEL ( LEVEL )
    ) i_node (
      .clk_i          ( clk_i        ),
      .arst_n_i       ( arst_n_i     ),
      .child_valid_i  ( ch_valid     ),
      .child_lvl_i    ( ch_lvl       ),
      .child_id_i     ( ch_id        ),
      .parent_valid_o ( par_valid[n] ),
      .parent_lvl_o   ( par_lvl[n]   ),
      .parent_id_o    ( par_id[n]    ),
      .wake_o         ( own_wake[n]  ),
      .wake_lvl_o     ( own_lvl[n]   ),
      .wake_id_o      ( own_id[n]    )
    );

    // Parent wakes only pass for barriers that span beyond this node
    assign node_wake = own_wake[n] || (dn_wake_i[n] && (dn_lvl_i[n] > OWN_LVL));

    assign dn_wake_d[CH0] = node_wake;
    assign dn_wake_d[CH1] = node_wake;
    assign dn_lvl_d[CH0]  = own_wake[n] ? own_lvl[n] : dn_lvl_i[n];
    assign dn_lvl_d[CH1]  = own_wake[n] ? own_lvl[n] : dn_lvl_i[n];
    assign dn_id_d[CH0]   = own_wake[n] ? own_id[n]  : dn_id_i[n];
    assign dn_id_d[CH1]   = own_wake[n] ? own_id[n]  : dn_id_i[n];
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      up_valid_o <= '0;
      dn_wake_o  <= '0;
    end else begin
      up_valid_o <= par_valid;
      dn_wake_o  <= dn_wake_d;
    end
  end

  always_ff @(posedge clk_i) begin
    up_lvl_o <= par_lvl;
    up_id_o  <= par_id;
    dn_lvl_o <= dn_lvl_d;
    dn_id_o  <= dn_id_d;
  end

  // One outstanding request per CU keeps own and parent wakes apart
  a_no_wake_clash : assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    (own_wake & dn_wake_i) == '0
  ) else $error("Level %0d node got its own wake and a parent wake together", LEVEL);

endmodule : fsync_level

/* hdl/fsync_node.sv */
// Tree node that pairs the requests of its two children per barrier id

`timescale 1ns/1ps

`include "fsync_cfg.svh"

module fsync_node #(
  parameter int unsigned LEVEL = 1
) (
  input  logic            clk_i,
  input  logic            arst_n_i,

  // Requests from the two children
  input  logic [1:0]      child_valid_i,
  input  fsync_pkg::lvl_t child_lvl_i [2],
  input  fsync_pkg::id_t  child_id_i  [2],

  // Merged request toward the parent
  output logic            parent_valid_o,
  output fsync_pkg::lvl_t parent_lvl_o,
  output fsync_pkg::id_t  parent_id_o,

  // Own wake toward both children
  output logic            wake_o,
  output fsync_pkg::lvl_t wake_lvl_o,
  output fsync_pkg::id_t  wake_id_o
);

  import fsync_pkg::*;

  localparam lvl_t OWN_LVL = lvl_t'(LEVEL);

  // Pending table, one bit per child and per barrier id
  logic [1:0][N_ID-1:0] pend_q;
  logic [1:0][N_ID-1:0] pend_d;

  // Level seen with each pending entry
  lvl_t                 pend_lvl_q [2][N_ID];

  logic                 done_0;
  logic                 done_1;
  logic                 done;
  lvl_t                 done_lvl;
  id_t                  done_id;

  logic                 same_cycle_pair;
  logic                 lvl_clash;
  logic [1:0]           dup_req;

  assign same_cycle_pair = (&child_valid_i) && (child_id_i[0] == child_id_i[1]);

  // Child 0 completes against a pending child 1 or a simultaneous match
  assign done_0 = child_valid_i[0] && (pend_q[1][child_id_i[0]] || same_cycle_pair);

  // Child 1 completes only against an older entry of child 0
  assign done_1 = child_valid_i[1] && pend_q[0][child_id_i[1]];

  // At most one pair can finish per cycle
  // since a child with an entry pending sends nothing new
  assign done     = done_0 || done_1;
  assign done_lvl = done_0 ? child_lvl_i[0] : child_lvl_i[1];
  assign done_id  = done_0 ? child_id_i[0]  : child_id_i[1];

  always_comb begin
    pend_d = pend_q;
    for (int c = 0; c < 2; c++) begin
      if (child_valid_i[c]) begin
        pend_d[c][child_id_i[c]] = 1'b1;
      end
    end
    // Completed id leaves the table for both children
    if (done) begin
      pend_d[0][done_id] = 1'b0;
      pend_d[1][done_id] = 1'b0;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      pend_q <= '0;
    end else begin
      pend_q <= pend_d;
    end
  end

  always_ff @(posedge clk_i) begin
    for (int c = 0; c < 2; c++) begin
      if (child_valid_i[c]) begin
        pend_lvl_q[c][child_id_i[c]] <= child_lvl_i[c];
      end
    end
  end

  // Barrier ends here or climbs one more level
  assign wake_o         = done && (done_lvl == OWN_LVL);
  assign wake_lvl_o     = done_lvl;
  assign wake_id_o      = done_id;

  assign parent_valid_o = done && (done_lvl > OWN_LVL);
  assign parent_lvl_o   = done_lvl;
  assign parent_id_o    = done_id;

  // Partners of one id must name the same level
  assign lvl_clash =
    (done_0 && pend_q[1][child_id_i[0]] &&
     (child_lvl_i[0] != pend_lvl_q[1][child_id_i[0]])) ||
    (done_0 && same_cycle_pair && (child_lvl_i[0] != child_lvl_i[1])) ||
    (done_1 && (child_lvl_i[1] != pend_lvl_q[0][child_id_i[1]]));

  always_comb begin
    for (int c = 0; c < 2; c++) begin
      dup_req[c] = child_valid_i[c] && pend_q[c][child_id_i[c]];
    end
  end

  a_lvl_agree : assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    !lvl_clash
  ) else $error("Children of level %0d node disagree on barrier level", LEVEL);

  a_no_dup : assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    dup_req == 2'b00
  ) else $error("Child of level %0d node repeats a pending barrier id", LEVEL);

endmodule : fsync_node

/* hdl/fsync_pkg.sv */
// Field and index types shared by all stages of the barrier network

`include "fsync_cfg.svh"

package fsync_pkg;

  // Number of distinct barrier ids
  localparam int unsigned N_ID = 2 ** `FSYNC_ID_W;

  // Target level of a request or a wake
  typedef logic [`FSYNC_LVL_W-1:0] lvl_t;

  // Barrier id carried along with the level
  typedef logic [`FSYNC_ID_W-1:0] id_t;

  // One bit per compute unit
  typedef logic [`FSYNC_N_CU-1:0] cu_mask_t;

endpackage : fsync_pkg

/* hdl/fsync_tree.sv */
// Barrier synchronization tree for the 16 CUs of a 4x4 tile grid

`timescale 1ns/1ps

`include "fsync_cfg.svh"

module fsync_tree (
  input  logic                clk_i,
  input  logic                arst_n_i,

  input  fsync_pkg::cu_mask_t req_valid_i,
  input  fsync_pkg::lvl_t     req_lvl_i  [`FSYNC_N_CU],
  input  fsync_pkg::id_t      req_id_i   [`FSYNC_N_CU],

  output fsync_pkg::cu_mask_t wake_o,
  output fsync_pkg::lvl_t     wake_lvl_o [`FSYNC_N_CU],
  output fsync_pkg::id_t      wake_id_o  [`FSYNC_N_CU],

  output fsync_pkg::cu_mask_t err_o
);

  import fsync_pkg::*;

  // Nodes per level, halving toward the root
  localparam int unsigned N1 = `FSYNC_N_CU / 2;
  localparam int unsigned N2 = `FSYNC_N_CU / 4;
  localparam int unsigned N3 = `FSYNC_N_CU / 8;
  localparam int unsigned N4 = `FSYNC_N_CU / 16;

  cu_mask_t          ing_valid;
  lvl_t              ing_lvl      [`FSYNC_N_CU];
  id_t               ing_id       [`FSYNC_N_CU];

  logic [N1-1:0]     l1_up_valid;
  lvl_t              l1_up_lvl    [N1];
  id_t               l1_up_id     [N1];
  logic [N2-1:0]     l2_up_valid;
  lvl_t              l2_up_lvl    [N2];
  id_t               l2_up_id     [N2];
  logic [N3-1:0]     l3_up_valid;
  lvl_t              l3_up_lvl    [N3];
  id_t               l3_up_id     [N3];

  // Down path, named after the level that drives it
  logic [N1-1:0]     l2_dn_wake;
  lvl_t              l2_dn_lvl    [N1];
  id_t               l2_dn_id     [N1];
  logic [N2-1:0]     l3_dn_wake;
  lvl_t              l3_dn_lvl    [N2];
  id_t               l3_dn_id     [N2];
  logic [N3-1:0]     l4_dn_wake;
  lvl_t              l4_dn_lvl    [N3];
  id_t               l4_dn_id     [N3];

  // Nothing sits above the root
  logic [N4-1:0]     root_dn_wake;
  lvl_t              root_dn_lvl  [N4];
  id_t               root_dn_id   [N4];

  assign root_dn_wake = '0;
  assign root_dn_lvl  = '{default: '0};
  assign root_dn_id   = '{default: '0};

  fsync_ingress i_ingress (
    .clk_i, .arst_n_i, .req_valid_i, .req_lvl_i, .req_id_i,
    .wake_i (wake_o), .up_valid_o (ing_valid), .up_lvl_o (ing_lvl), .up_id_o (ing_id),
    .err_o
  );

  fsync_level #(.LEVEL (1), .N_NODES (N1)) i_level1 (
    .clk_i, .arst_n_i,
    .up_valid_i (ing_valid),   .up_lvl_i (ing_lvl),   .up_id_i (ing_id),
    .up_valid_o (l1_up_valid), .up_lvl_o (l1_up_lvl), .up_id_o (l1_up_id),
    .dn_wake_i  (l2_dn_wake),  .dn_lvl_i (l2_dn_lvl), .dn_id_i (l2_dn_id),
    .dn_wake_o  (wake_o),      .dn_lvl_o (wake_lvl_o), .dn_id_o (wake_id_o)
  );

  fsync_level #(.LEVEL (2), .N_NODES (N2)) i_level2 (
    .clk_i, .arst_n_i,
    .up_valid_i (l1_up_valid), .up_lvl_i (l1_up_lvl), .up_id_i (l1_up_id),
    .up_valid_o (l2_up_valid), .up_lvl_o (l2_up_lvl), .up_id_o (l2_up_id),
    .dn_wake_i  (l3_dn_wake),  .dn_lvl_i (l3_dn_lvl), .dn_id_i (l3_dn_id),
    .dn_wake_o  (l2_dn_wake),  .dn_lvl_o (l2_dn_lvl), .dn_id_o (l2_dn_id)
  );

  fsync_level #(.LEVEL (3), .N_NODES (N3)) i_level3 (
    .clk_i, .arst_n_i,
    .up_valid_i (l2_up_valid), .up_lvl_i (l2_up_lvl), .up_id_i (l2_up_id),
    .up_valid_o (l3_up_valid), .up_lvl_o (l3_up_lvl), .up_id_o (l3_up_id),
    .dn_wake_i  (l4_dn_wake),  .dn_lvl_i (l4_dn_lvl), .dn_id_i (l4_dn_id),
    .dn_wake_o  (l3_dn_wake),  .dn_lvl_o (l3_dn_lvl), .dn_id_o (l3_dn_id)
  );

  // Root level, its up outputs lead nowhere
  fsync_level #(.LEVEL (4), .N_NODES (N4)) i_level4 (
    .clk_i, .arst_n_i,
    .up_valid_i (l3_up_valid),  .up_lvl_i (l3_up_lvl),   .up_id_i (l3_up_id),
    .up_valid_o (),             .up_lvl_o (),            .up_id_o (),
    .dn_wake_i  (root_dn_wake), .dn_lvl_i (root_dn_lvl), .dn_id_i (root_dn_id),
    .dn_wake_o  (l4_dn_wake),   .dn_lvl_o (l4_dn_lvl),   .dn_id_o (l4_dn_id)
  );

endmodule : fsync_tree

/* include/fsync_cfg.svh */
// Sizing macros of the barrier synchronization network

`ifndef FSYNC_CFG_SVH
`define FSYNC_CFG_SVH

// Compute units in the 4x4 tile grid
`define FSYNC_N_CU 16

// Tree levels, alternating horizontal and vertical pairing
`define FSYNC_N_LEVELS 4

// Request level field, legal values 1 to FSYNC_N_LEVELS
`define FSYNC_LVL_W 3

// Barrier id field
`define FSYNC_ID_W 2

`endif

/* run_sim.sh */
#!/bin/sh
# Compile the barrier tree testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing -f all.f --top-module tb_fsync_tree \
  -Mdir obj_dir -o sim_fsync
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator compile failed with status $status"
  exit $status
fi

./obj_dir/sim_fsync
status=$?
if [ $status -ne 0 ]; then
  echo "Simulation ended with status $status"
  exit $status
fi

exit 0

/* sim/fsync_stimulus.txt */
# Hex columns: mask_a lvl_a id_a mask_b lvl_b id_b delay_b wake_mask err_mask
# Group b is presented delay_b cycles after group a
0000 0 0 0000 0 0 0 0000 0000
0003 1 1 0000 0 0 0 0003 0000
00ff 4 2 ff00 4 2 2 ffff 0000
3333 2 1 00cc 2 2 1 33ff 0000
00ff 3 0 0c00 1 3 0 0cff 0000
0100 0 0 0200 5 1 0 0000 0300
0031 2 0 0003 2 0 2 0033 0001
8000 1 3 0000 0 0 0 0000 0000

/* sim/tb_fsync_tree.sv */
// Testbench for the barrier tree, driven by steps read from the stimulus file

`timescale 1ns/1ps

`include "fsync_cfg.svh"

module tb_fsync_tree;

  import fsync_pkg::*;

  localparam int MAX_STEPS = 32;

  logic     clk_i = 1'b0;
  logic     arst_n_i = 1'b0;
  cu_mask_t req_valid_i;
  lvl_t     req_lvl_i  [`FSYNC_N_CU];
  id_t      req_id_i   [`FSYNC_N_CU];
  cu_mask_t wake_o;
  lvl_t     wake_lvl_o [`FSYNC_N_CU];
  id_t      wake_id_o  [`FSYNC_N_CU];
  cu_mask_t err_o;

  // Step table loaded from the file
  cu_mask_t st_mask_a [MAX_STEPS];
  cu_mask_t st_mask_b [MAX_STEPS];
  lvl_t     st_lvl_a  [MAX_STEPS];
  lvl_t     st_lvl_b  [MAX_STEPS];
  id_t      st_id_a   [MAX_STEPS];
  id_t      st_id_b   [MAX_STEPS];
  int       st_delay  [MAX_STEPS];
  cu_mask_t st_wake   [MAX_STEPS];
  cu_mask_t st_err    [MAX_STEPS];
  int       n_steps = 0;
  int       cycles  = 0;

  // Expected response per CU, relative to the step start
  int       wake_at [`FSYNC_N_CU];
  int       err_at  [`FSYNC_N_CU];
  lvl_t     exp_lvl [`FSYNC_N_CU];
  id_t      exp_id  [`FSYNC_N_CU];

  fsync_tree UUT (
    .clk_i, .arst_n_i, .req_valid_i, .req_lvl_i, .req_id_i,
    .wake_o, .wake_lvl_o, .wake_id_o, .err_o
  );

  always #20 clk_i = ~clk_i;

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("Testbench failed");
    $fatal(1);
  endtask

  task automatic check_wake(input cu_mask_t exp_mask, input lvl_t lvl [`FSYNC_N_CU],
                            input id_t id [`FSYNC_N_CU]);
    if (wake_o !== exp_mask) begin
      report_failure($sformatf("[ERROR] wake_o expected %h got %h", exp_mask, wake_o));
    end
    for (int i = 0; i < `FSYNC_N_CU; i++) begin
      if (exp_mask[i] && (wake_lvl_o[i] !== lvl[i])) begin
        report_failure($sformatf("[ERROR] wake_lvl_o[%0d] expected %h got %h",
                                 i, lvl[i], wake_lvl_o[i]));
      end
      if (exp_mask[i] && (wake_id_o[i] !== id[i])) begin
        report_failure($sformatf("[ERROR] wake_id_o[%0d] expected %h got %h",
                                 i, id[i], wake_id_o[i]));
      end
    end
  endtask

  task automatic check_err(input cu_mask_t exp_mask);
    if (err_o !== exp_mask) begin
      report_failure($sformatf("[ERROR] err_o expected %h got %h", exp_mask, err_o));
    end
  endtask

  task automatic load_steps();
    int    fd;
    int    cnt;
    int    f [9];
    string line;
    fd = $fopen("sim/fsync_stimulus.txt", "r");
    if (fd == 0) begin
      report_failure("Could not open the stimulus file");
    end
    while (!$feof(fd) && n_steps < MAX_STEPS) begin
      line = "";
      cnt = $fgets(line, fd);
      if (cnt > 0 && line.len() > 0 && line[0] != "#") begin
        cnt = $sscanf(line, "%h %h %h %h %h %h %h %h %h",
                      f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8]);
        if (cnt == 9) begin
          st_mask_a[n_steps] = cu_mask_t'(f[0]);
          st_lvl_a[n_steps]  = lvl_t'(f[1]);
          st_id_a[n_steps]   = id_t'(f[2]);
          st_mask_b[n_steps] = cu_mask_t'(f[3]);
          st_lvl_b[n_steps]  = lvl_t'(f[4]);
          st_id_b[n_steps]   = id_t'(f[5]);
          st_delay[n_steps]  = f[6];
          st_wake[n_steps]   = cu_mask_t'(f[7]);
          st_err[n_steps]    = cu_mask_t'(f[8]);
          n_steps++;
        end
      end
    end
    $fclose(fd);
    if (n_steps == 0) begin
      report_failure("The stimulus file holds no steps");
    end
  endtask

  // Requests with equal level and id form one barrier that completes with its last request
  task automatic plan_step(input int s);
    int last_a;
    int last_b;
    logic same;
    same   = (st_mask_b[s] != '0) && (st_lvl_a[s] == st_lvl_b[s]) &&
             (st_id_a[s] == st_id_b[s]);
    last_a = same ? st_delay[s] : 0;
    last_b = st_delay[s];
    for (int i = 0; i < `FSYNC_N_CU; i++) begin
      wake_at[i] = -1;
      err_at[i]  = -1;
      if (st_wake[s][i] && st_mask_a[s][i]) begin
        wake_at[i] = last_a + 2 * int'(st_lvl_a[s]);
        exp_lvl[i] = st_lvl_a[s];
        exp_id[i]  = st_id_a[s];
      end else if (st_wake[s][i]) begin
        wake_at[i] = last_b + 2 * int'(st_lvl_b[s]);
        exp_lvl[i] = st_lvl_b[s];
        exp_id[i]  = st_id_b[s];
      end
      if (st_err[s][i]) begin
        err_at[i] = st_mask_b[s][i] ? st_delay[s] + 1 : 1;
      end
    end
  endtask

  task automatic run_step(input int s, input int gap);
    int       window;
    cu_mask_t drive;
    cu_mask_t exp_wake;
    cu_mask_t exp_err;
    window = st_delay[s] + 2 * `FSYNC_N_LEVELS + 2 + gap;
    for (int t = 0; t < window; t++) begin
      @(posedge clk_i);
      drive = '0;
      for (int i = 0; i < `FSYNC_N_CU; i++) begin
        if (t == 0 && st_mask_a[s][i]) begin
          drive[i] = 1'b1;
          req_lvl_i[i] <= st_lvl_a[s];
          req_id_i[i]  <= st_id_a[s];
        end
        if (t == st_delay[s] && st_mask_b[s][i]) begin
          drive[i] = 1'b1;
          req_lvl_i[i] <= st_lvl_b[s];
          req_id_i[i]  <= st_id_b[s];
        end
      end
      req_valid_i <= drive;
      @(negedge clk_i);
      exp_wake = '0;
      exp_err  = '0;
      for (int i = 0; i < `FSYNC_N_CU; i++) begin
        exp_wake[i] = (wake_at[i] == t);
        exp_err[i]  = (err_at[i] == t);
      end
      check_wake(exp_wake, exp_lvl, exp_id);
      check_err(exp_err);
    end
  endtask

  // Run limit from the step count, as each step takes at most about 14 cycles
  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (n_steps > 0 && cycles > n_steps * (2 * `FSYNC_N_LEVELS + 6) + 20) begin
      report_failure("Timeout: the run took more cycles than the steps allow");
    end
  end

  initial begin
    void'($urandom(32'h7c41f301));
    req_valid_i = '0;
    req_lvl_i   = '{default: '0};
    req_id_i    = '{default: '0};
    exp_lvl     = '{default: '0};
    exp_id      = '{default: '0};
    load_steps();
    repeat (3) @(posedge clk_i);
    arst_n_i <= 1'b1;
    for (int s = 0; s < n_steps; s++) begin
      plan_step(s);
      run_step(s, int'($urandom_range(3, 0)));
    end
    $display("Testbench passed");
    $finish;
  end

endmodule : tb_fsync_tree
